//--- verilog/bus_pkg.sv
// Bus widths, host and device sets, and the fixed address map.
// The RAM window mask depends on the RAM depth, so the bus derives it.
`default_nettype none

package bus_pkg;

  localparam int unsigned BusAddrWidth = 32;
  localparam int unsigned BusDataWidth = 32;
  localparam int unsigned BusBeWidth   = BusDataWidth / 8;

  // Hosts in decreasing priority
  typedef enum logic [1:0] {
    HostTestUtil,
    HostCoreD,
    HostCoreI
  } bus_host_e;

  typedef enum logic {
    DevRam,
    DevTestUtil
  } bus_device_e;

  localparam int unsigned NrHosts   = int'(HostCoreI) + 1;
  localparam int unsigned NrDevices = int'(DevTestUtil) + 1;

  // Request from a host, or forwarded to a device
  typedef struct packed {
    logic                    req;
    logic [BusAddrWidth-1:0] addr;
    logic                    we;
    logic [BusBeWidth-1:0]   be;
    logic [BusDataWidth-1:0] wdata;
  } bus_req_t;

  // Response, valid one cycle after the grant
  typedef struct packed {
    logic                    rvalid;
    logic [BusDataWidth-1:0] rdata;
    logic                    err;
  } bus_rsp_t;

  // Address map
  localparam logic [BusAddrWidth-1:0] RamBase      = 32'h0000_0000;
  localparam logic [BusAddrWidth-1:0] TestUtilBase = 32'h0002_0000;
  // 1 kB register window
  localparam logic [BusAddrWidth-1:0] TestUtilMask = ~32'h0000_03FF;

endpackage

`default_nettype wire

//--- verilog/testutil_pkg.sv
// Test utility register map and dump engine states.
// Offsets are relative to the 1 kB test utility window.
`default_nettype none

package testutil_pkg;

  localparam int unsigned RegOffsetWidth = 10;

  localparam logic [RegOffsetWidth-1:0] RegSigBegin = 10'h000;
  localparam logic [RegOffsetWidth-1:0] RegSigEnd   = 10'h004;
  localparam logic [RegOffsetWidth-1:0] RegHalt     = 10'h008;

  // Dump engine
  typedef enum logic [1:0] {
    TuIdle,   // registers only
    TuDump,   // issuing reads
    TuDrain,  // waiting for last response
    TuDone    // dump finished
  } testutil_state_e;

endpackage

`default_nettype wire

//--- verilog/bus.sv
// Fixed-priority bus, three hosts and two devices, one access granted per cycle.
// Unmapped addresses get an error response one cycle after the grant.
// RamWords must be a power of two.
`default_nettype none
`timescale 1ns/100ps

module bus
  import bus_pkg::*;
#(
  parameter int unsigned RamWords = 16384
) (
  input  logic     clk_i,
  input  logic     reset_i,

  input  bus_req_t host_req_i [NrHosts],
  output logic     host_gnt_o [NrHosts],
  output bus_rsp_t host_rsp_o [NrHosts],

  output bus_req_t dev_req_o  [NrDevices],
  input  bus_rsp_t dev_rsp_i  [NrDevices]
);

  localparam logic [BusAddrWidth-1:0] RamMask = ~(BusAddrWidth'(RamWords * 4 - 1));

  logic                    gnt_any;
  bus_host_e               gnt_idx;
  logic [NrHosts-1:0]      gnt_vec;
  logic [BusAddrWidth-1:0] gnt_addr;
  logic                    dev_hit;
  bus_device_e             dev_idx;

  // Response steering
  logic                    rsp_pending_q;
  logic                    rsp_unmapped_q;
  bus_host_e               rsp_host_q;
  bus_device_e             rsp_dev_q;

  // Lowest index wins, so scan from the bottom of the priority order
  always_comb begin
    gnt_any = 1'b0;
    gnt_idx = HostTestUtil;
    for (int h = NrHosts - 1; h >= 0; h--) begin
      if (host_req_i[h].req) begin
        gnt_any = 1'b1;
        gnt_idx = bus_host_e'(h);
      end
    end
  end

  always_comb begin
    for (int h = 0; h < NrHosts; h++) begin
      gnt_vec[h]    = gnt_any && (gnt_idx == bus_host_e'(h));
      host_gnt_o[h] = gnt_vec[h];
    end
  end

  // Base and mask decode of the winning address
  always_comb begin
    gnt_addr = host_req_i[gnt_idx].addr;
    dev_hit  = 1'b1;
    dev_idx  = DevRam;
    if ((gnt_addr & RamMask) == RamBase) begin
      dev_idx = DevRam;
    end else if ((gnt_addr & TestUtilMask) == TestUtilBase) begin
      dev_idx = DevTestUtil;
    end else begin
      dev_hit = 1'b0;
    end
  end

  // All devices see the fields, only the selected one sees req
  always_comb begin
    for (int d = 0; d < NrDevices; d++) begin
      dev_req_o[d]     = host_req_i[gnt_idx];
      dev_req_o[d].req = gnt_any && dev_hit && (dev_idx == bus_device_e'(d));
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_pending_q  <= 1'b0;
      rsp_unmapped_q <= 1'b0;
      rsp_host_q     <= HostTestUtil;
      rsp_dev_q      <= DevRam;
    end else begin
      rsp_pending_q <= gnt_any;
      if (gnt_any) begin
        rsp_unmapped_q <= ~dev_hit;
        rsp_host_q     <= gnt_idx;
        rsp_dev_q      <= dev_idx;
      end
    end
  end

  // Route the device answer, or a local error, back to the granted host
  always_comb begin
    for (int h = 0; h < NrHosts; h++) begin
      host_rsp_o[h] = '0;
    end
    if (rsp_pending_q) begin
      if (rsp_unmapped_q) begin
        host_rsp_o[rsp_host_q].rvalid = 1'b1;
        host_rsp_o[rsp_host_q].err    = 1'b1;
      end else begin
        host_rsp_o[rsp_host_q] = dev_rsp_i[rsp_dev_q];
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_vec))
    else $error("more than one host granted");

  for (genvar h = 0; h < NrHosts; h++) begin : g_rsp_check
    assert property (@(posedge clk_i) disable iff (reset_i)
                     host_rsp_o[h].rvalid |-> $past(gnt_vec[h]))
      else $error("response to host %0d without a grant", h);
  end

endmodule

`default_nettype wire

//--- verilog/ram_1p.sv
// Single-port word RAM with byte enables and a one-cycle response.
// Depth must be a power of two; the contents are not reset.
`default_nettype none
`timescale 1ns/100ps

module ram_1p
  import bus_pkg::*;
#(
  parameter int unsigned Depth = 16384
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  localparam int unsigned WordBits = $clog2(Depth);
  localparam int unsigned ByteBits = $clog2(BusBeWidth);

  logic [BusDataWidth-1:0] mem [Depth];
  logic [WordBits-1:0]     word_addr;
  logic [BusDataWidth-1:0] rdata_q;
  logic                    rvalid_q;

  // Byte offset dropped
  assign word_addr = req_i.addr[WordBits+ByteBits-1:ByteBits];

  // Read returns the contents before any write at the same edge
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= mem[word_addr];
      if (req_i.we) begin
        for (int b = 0; b < BusBeWidth; b++) begin
          if (req_i.be[b]) begin
            mem[word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};

  assert property (@(posedge clk_i) disable iff (reset_i) req_i.req |=> rsp_o.rvalid)
    else $error("RAM response missing");

  // Full-word write followed by a read of that word returns the new data
  assert property (@(posedge clk_i) disable iff (reset_i)
                   (req_i.req && req_i.we && (&req_i.be))
                   ##1 (req_i.req && !req_i.we && (req_i.addr == $past(req_i.addr)))
                   |=> (rsp_o.rdata == $past(req_i.wdata, 2)))
    else $error("RAM read after write returned stale data");

endmodule

`default_nettype wire

//--- verilog/riscv_testutil.sv
// Register device for the signature bounds and halt, plus a read-only host.
// After a halt write it reads [SigBegin, SigEnd) word by word and streams it out.
// Register writes need all four byte enables.
`default_nettype none
`timescale 1ns/100ps

module riscv_testutil
  import bus_pkg::*;
  import testutil_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,

  input  bus_req_t    dev_req_i,
  output bus_rsp_t    dev_rsp_o,

  output bus_req_t    host_req_o,
  input  logic        host_gnt_i,
  input  bus_rsp_t    host_rsp_i,

  output logic        sig_valid_o,
  output logic [31:0] sig_data_o,
  output logic        halted_o
);

  testutil_state_e             state_q, state_d;
  logic [BusAddrWidth-1:0]     sig_begin_q, sig_end_q;
  logic [BusAddrWidth-1:0]     rd_addr_q, rd_addr_d;
  logic [BusAddrWidth-1:0]     dump_start;
  logic [1:0]                  outstanding_q, outstanding_d;
  logic                        host_issue;

  logic [RegOffsetWidth-1:0]   reg_offset;
  logic                        acc_err;
  logic [BusDataWidth-1:0]     acc_rdata;
  logic                        wr_en, wr_begin, wr_end, wr_halt;
  logic                        dev_rvalid_q, dev_err_q;
  logic [BusDataWidth-1:0]     dev_rdata_q;

  // Register decode
  assign reg_offset = dev_req_i.addr[RegOffsetWidth-1:0];

  always_comb begin
    acc_err   = 1'b0;
    acc_rdata = '0;
    case (reg_offset)
      RegSigBegin: acc_rdata = sig_begin_q;
      RegSigEnd:   acc_rdata = sig_end_q;
      RegHalt:     acc_rdata = {{(BusDataWidth-1){1'b0}}, halted_o};
      default:     acc_err   = 1'b1;
    endcase
    if (dev_req_i.we && !(&dev_req_i.be)) begin
      acc_err = 1'b1;
    end
  end

  assign wr_en    = dev_req_i.req && dev_req_i.we && !acc_err;
  assign wr_begin = wr_en && (reg_offset == RegSigBegin);
  assign wr_end   = wr_en && (reg_offset == RegSigEnd);
  assign wr_halt  = wr_en && (reg_offset == RegHalt);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sig_begin_q  <= '0;
      sig_end_q    <= '0;
      dev_rvalid_q <= 1'b0;
    end else begin
      dev_rvalid_q <= dev_req_i.req;
      if (wr_begin) sig_begin_q <= dev_req_i.wdata;
      if (wr_end)   sig_end_q   <= dev_req_i.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dev_req_i.req) begin
      dev_rdata_q <= acc_rdata;
      dev_err_q   <= acc_err;
    end
  end

  assign dev_rsp_o = '{rvalid: dev_rvalid_q, rdata: dev_rdata_q, err: dev_err_q};

  // Dump engine
  assign dump_start = {sig_begin_q[BusAddrWidth-1:2], 2'b00};
  assign host_issue = host_req_o.req && host_gnt_i;

  always_comb begin
    state_d       = state_q;
    rd_addr_d     = rd_addr_q;
    outstanding_d = outstanding_q + 2'(host_issue) - 2'(host_rsp_i.rvalid);
    case (state_q)
      TuIdle: begin
        if (wr_halt) begin
          rd_addr_d = dump_start;
          // Empty region goes straight to done
          state_d   = (sig_end_q > dump_start) ? TuDump : TuDone;
        end
      end
      TuDump: begin
        if (host_issue) begin
          rd_addr_d = rd_addr_q + BusAddrWidth'(4);
          if (rd_addr_d >= sig_end_q) state_d = TuDrain;
        end
      end
      TuDrain: begin
        if (outstanding_d == '0) state_d = TuDone;
      end
      TuDone: state_d = TuDone;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q       <= TuIdle;
      rd_addr_q     <= '0;
      outstanding_q <= '0;
    end else begin
      state_q       <= state_d;
      rd_addr_q     <= rd_addr_d;
      outstanding_q <= outstanding_d;
    end
  end

  always_comb begin
    host_req_o      = '0;
    host_req_o.req  = (state_q == TuDump);
    host_req_o.addr = rd_addr_q;
    host_req_o.be   = '1;
  end

  // Each read response is one signature word
  assign sig_valid_o = host_rsp_i.rvalid;
  assign sig_data_o  = host_rsp_i.rdata;
  assign halted_o    = (state_q == TuDone);

  // Done only once every dump read has come back
  assert property (@(posedge clk_i) disable iff (reset_i)
                   (state_q == TuDone) |-> (outstanding_q == '0) && !host_rsp_i.rvalid)
    else $error("test utility done with a dump read outstanding");

endmodule

`default_nettype wire

//--- verilog/compliance_harness.sv
// Compliance harness without a CPU core; the core host ports are exposed.
// Both core ports see one cycle from grant to response.
`default_nettype none
`timescale 1ns/100ps

module compliance_harness
  import bus_pkg::*;
#(
  parameter int unsigned RamWords = 16384
) (
  input  logic        clk_i,
  input  logic        reset_i,

  input  bus_req_t    core_i_req_i,
  output logic        core_i_gnt_o,
  output bus_rsp_t    core_i_rsp_o,

  input  bus_req_t    core_d_req_i,
  output logic        core_d_gnt_o,
  output bus_rsp_t    core_d_rsp_o,

  output logic        sig_valid_o,
  output logic [31:0] sig_data_o,
  output logic        halted_o
);

  bus_req_t host_req [NrHosts];
  logic     host_gnt [NrHosts];
  bus_rsp_t host_rsp [NrHosts];
  bus_req_t dev_req  [NrDevices];
  bus_rsp_t dev_rsp  [NrDevices];

  // Core ports
  assign host_req[HostCoreI] = core_i_req_i;
  assign host_req[HostCoreD] = core_d_req_i;
  assign core_i_gnt_o        = host_gnt[HostCoreI];
  assign core_i_rsp_o        = host_rsp[HostCoreI];
  assign core_d_gnt_o        = host_gnt[HostCoreD];
  assign core_d_rsp_o        = host_rsp[HostCoreD];

  bus #(
    .RamWords(RamWords)
  ) u_bus (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .host_req_i (host_req),
    .host_gnt_o (host_gnt),
    .host_rsp_o (host_rsp),
    .dev_req_o  (dev_req),
    .dev_rsp_i  (dev_rsp)
  );

  ram_1p #(
    .Depth(RamWords)
  ) u_ram (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (dev_req[DevRam]),
    .rsp_o   (dev_rsp[DevRam])
  );

  // Device and top-priority host at once
  riscv_testutil u_riscv_testutil (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .dev_req_i   (dev_req[DevTestUtil]),
    .dev_rsp_o   (dev_rsp[DevTestUtil]),
    .host_req_o  (host_req[HostTestUtil]),
    .host_gnt_i  (host_gnt[HostTestUtil]),
    .host_rsp_i  (host_rsp[HostTestUtil]),
    .sig_valid_o (sig_valid_o),
    .sig_data_o  (sig_data_o),
    .halted_o    (halted_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// Free-running 8 ns clock and a power-on reset held for ResetCycles rising edges.
`default_nettype none
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #4;
      clk_o = ~clk_o;
    end
  end

  // Released just after an edge, like the other inputs
  initial begin
    reset_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/tb_compliance_harness.sv
// Testbench that plays the core on both host ports of the harness.
// Only RAM words that were written are ever read back or dumped.
`default_nettype none
`timescale 1ns/100ps

module tb_compliance_harness
  import bus_pkg::*;
  import testutil_pkg::*;
;

  localparam int PortD       = 0;
  localparam int PortI       = 1;
  localparam int ResetCycles = 8;
  localparam int Timeout     = 64;
  localparam int SigWords    = 8;
  localparam int DriveDelay  = 1;

  // Expected response of one core port
  typedef struct packed {
    logic        chk;
    logic        err;
    logic [31:0] rdata;
  } expect_t;

  logic        clk;
  logic        por_reset;
  logic        soft_reset;
  logic        reset;
  bus_req_t    core_req [2];
  logic        core_gnt [2];
  bus_rsp_t    core_rsp [2];
  expect_t     exp_rsp  [2];
  time         gnt_time [2];
  logic        sig_valid;
  logic        halted;
  logic        dump_window;
  logic [31:0] sig_data;
  logic [31:0] sig_exp [SigWords];
  int unsigned sig_len;
  int unsigned sig_count;
  integer      seed;
  string       test_name;
  logic [7:0]  model_mem [int unsigned];

  assign reset = por_reset | soft_reset;

  tb_clock_gen #(
    .ResetCycles(ResetCycles)
  ) i_clock_gen (
    .clk_o   (clk),
    .reset_o (por_reset)
  );

  compliance_harness i_dut (
    .clk_i        (clk),
    .reset_i      (reset),
    .core_i_req_i (core_req[PortI]),
    .core_i_gnt_o (core_gnt[PortI]),
    .core_i_rsp_o (core_rsp[PortI]),
    .core_d_req_i (core_req[PortD]),
    .core_d_gnt_o (core_gnt[PortD]),
    .core_d_rsp_o (core_rsp[PortD]),
    .sig_valid_o  (sig_valid),
    .sig_data_o   (sig_data),
    .halted_o     (halted)
  );

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", what, expected, actual));
  endtask

  // Byte-level RAM model
  function automatic logic [31:0] model_word(input logic [31:0] addr);
    logic [31:0] word;
    for (int b = 0; b < 4; b++) begin
      word[8*b +: 8] = model_mem.exists(addr + b) ? model_mem[addr + b] : 8'hxx;
    end
    return word;
  endfunction

  function automatic void model_write(input logic [31:0] addr, input logic [3:0] be,
                                      input logic [31:0] data);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) model_mem[addr + b] = data[8*b +: 8];
    end
  endfunction

  // One access on a core port; the response is checked by the assertions below
  task automatic bus_access(input int port, input logic [31:0] addr, input logic we,
                            input logic [3:0] be, input logic [31:0] wdata,
                            input expect_t expected);
    int cycles;
    @(posedge clk);
    #DriveDelay;
    core_req[port] = '{req: 1'b1, addr: addr, we: we, be: be, wdata: wdata};
    cycles = 0;
    @(negedge clk);
    while (!core_gnt[port] && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!core_gnt[port]) stop_with_failure($sformatf("%s: port %0d never granted",
                                                      test_name, port));
    exp_rsp[port]  = expected;
    gnt_time[port] = $time;
    @(posedge clk);
    #DriveDelay;
    core_req[port] = '0;
    cycles = 0;
    @(negedge clk);
    while (!core_rsp[port].rvalid && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!core_rsp[port].rvalid) stop_with_failure($sformatf("%s: port %0d got no response",
                                                             test_name, port));
  endtask

  task automatic ram_write(input int port, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] data);
    bus_access(port, addr, 1'b1, be, data, '{chk: 1'b0, err: 1'b0, rdata: '0});
    model_write(addr, be, data);
  endtask

  task automatic ram_read(input int port, input logic [31:0] addr);
    bus_access(port, addr, 1'b0, 4'h0, '0, '{chk: 1'b1, err: 1'b0, rdata: model_word(addr)});
  endtask

  task automatic wait_halted();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!halted && cycles < Timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) stop_with_failure($sformatf("%s: halted never rose", test_name));
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #DriveDelay;
    soft_reset = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    soft_reset = 1'b0;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      sig_count <= 0;
    end else if (sig_valid) begin
      sig_count <= sig_count + 1;
    end
  end

  for (genvar p = 0; p < 2; p++) begin : g_port_check
    assert property (@(posedge clk) disable iff (reset) core_gnt[p] |=> core_rsp[p].rvalid)
      else stop_with_failure($sformatf("%s: port %0d response not one cycle after grant",
                                       test_name, p));
    assert property (@(posedge clk) disable iff (reset) core_rsp[p].rvalid |-> $past(core_gnt[p]))
      else stop_with_failure($sformatf("%s: port %0d response without grant", test_name, p));
    assert property (@(posedge clk) disable iff (reset)
                     core_rsp[p].rvalid |-> core_rsp[p].err == exp_rsp[p].err)
      else report_mismatch($sformatf("%s port %0d err", test_name, p),
                           $sampled(exp_rsp[p].err), $sampled(core_rsp[p].err));
    assert property (@(posedge clk) disable iff (reset)
                     core_rsp[p].rvalid && exp_rsp[p].chk |-> core_rsp[p].rdata == exp_rsp[p].rdata)
      else report_mismatch($sformatf("%s port %0d rdata", test_name, p),
                           $sampled(exp_rsp[p].rdata), $sampled(core_rsp[p].rdata));
  end

  assert property (@(posedge clk) reset |=> !halted && !sig_valid
                   && !core_rsp[PortD].rvalid && !core_rsp[PortI].rvalid)
    else stop_with_failure("outputs not idle after reset");
  assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else stop_with_failure($sformatf("%s: halted dropped without reset", test_name));
  assert property (@(posedge clk) disable iff (reset) sig_valid |-> sig_count < sig_len)
    else stop_with_failure($sformatf("%s: more signature words than expected", test_name));
  assert property (@(posedge clk) disable iff (reset)
                   sig_valid && sig_count < sig_len |-> sig_data == sig_exp[sig_count])
    else report_mismatch($sformatf("%s word %0d", test_name, $sampled(sig_count)),
                         sig_exp[$sampled(sig_count)], $sampled(sig_data));
  // Core ports wait while the dump still issues reads
  assert property (@(posedge clk) disable iff (reset)
                   dump_window && (sig_count + sig_valid < sig_len)
                   |-> !core_gnt[PortD] && !core_gnt[PortI])
    else stop_with_failure($sformatf("%s: core granted during the dump", test_name));

  initial begin
    int          cycles;
    logic [31:0] data;
    logic [3:0]  be;
    seed            = 32'he045_e043;
    core_req[PortD] = '0;
    core_req[PortI] = '0;
    exp_rsp[PortD]  = '0;
    exp_rsp[PortI]  = '0;
    soft_reset      = 1'b0;
    dump_window     = 1'b0;
    sig_len         = 0;
    test_name       = "reset";
    cycles          = 0;
    @(negedge clk);
    while (reset && cycles < 4 * ResetCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (reset) stop_with_failure("reset never released");

    // Full words first so that partial writes merge into known bytes
    test_name = "ram_access";
    for (int w = 0; w < 8; w++) begin
      ram_write(PortD, 32'(4 * w), 4'hf, $random(seed));
    end
    for (int w = 0; w < 8; w++) begin
      be   = 4'($random(seed));
      data = $random(seed);
      ram_write(PortD, 32'(4 * w), be, data);
    end
    for (int w = 0; w < 8; w++) begin
      ram_read(PortD, 32'(4 * w));
    end

    test_name = "arbitration";
    fork
      ram_read(PortD, 32'h4);
      ram_read(PortI, 32'h8);
    join
    assert (gnt_time[PortD] < gnt_time[PortI])
      else stop_with_failure("arbitration: instruction port not granted after data port");

    // 0x1_0000 would alias RAM word 0 if the decode were wrong
    test_name = "unmapped";
    bus_access(PortD, 32'h0001_0000, 1'b1, 4'hf, 32'hdead_beef, '{chk: 0, err: 1, rdata: '0});
    bus_access(PortD, 32'h8000_0000, 1'b0, 4'h0, '0, '{chk: 0, err: 1, rdata: '0});
    bus_access(PortI, 32'h0002_0400, 1'b0, 4'h0, '0, '{chk: 0, err: 1, rdata: '0});
    ram_read(PortD, 32'h0);

    test_name = "testutil_regs";
    bus_access(PortD, TestUtilBase + RegSigBegin, 1'b1, 4'hf, 32'h200, '{0, 0, '0});
    bus_access(PortD, TestUtilBase + RegSigEnd, 1'b1, 4'hf, 32'h220, '{0, 0, '0});
    bus_access(PortD, TestUtilBase + RegSigBegin, 1'b0, 4'h0, '0, '{1, 0, 32'h200});
    bus_access(PortD, TestUtilBase + RegSigEnd, 1'b0, 4'h0, '0, '{1, 0, 32'h220});
    bus_access(PortD, TestUtilBase + RegHalt, 1'b0, 4'h0, '0, '{1, 0, 32'h0});
    bus_access(PortD, TestUtilBase + 32'hc, 1'b0, 4'h0, '0, '{0, 1, '0});
    bus_access(PortD, TestUtilBase + RegSigBegin, 1'b1, 4'h3, 32'hffff, '{0, 1, '0});
    bus_access(PortD, TestUtilBase + RegSigBegin, 1'b0, 4'h0, '0, '{1, 0, 32'h200});

    test_name = "signature_dump";
    for (int w = 0; w < SigWords; w++) begin
      data       = $random(seed);
      sig_exp[w] = data;
      ram_write(PortD, 32'h200 + 32'(4 * w), 4'hf, data);
    end
    sig_len = SigWords;
    bus_access(PortD, TestUtilBase + RegHalt, 1'b1, 4'hf, 32'h1, '{0, 0, '0});
    dump_window = 1'b1;
    fork
      ram_read(PortI, 32'h0);
      wait_halted();
    join
    assert (sig_count == sig_len)
      else report_mismatch("signature_dump word count", sig_len, sig_count);
    dump_window = 1'b0;
    bus_access(PortD, TestUtilBase + RegHalt, 1'b0, 4'h0, '0, '{1, 0, 32'h1});
    repeat (4) @(posedge clk);

    test_name = "empty_dump";
    sig_len   = 0;
    apply_reset();
    bus_access(PortD, TestUtilBase + RegSigBegin, 1'b1, 4'hf, 32'h300, '{0, 0, '0});
    bus_access(PortD, TestUtilBase + RegSigEnd, 1'b1, 4'hf, 32'h300, '{0, 0, '0});
    bus_access(PortD, TestUtilBase + RegHalt, 1'b1, 4'hf, 32'h1, '{0, 0, '0});
    wait_halted();
    assert (sig_count == 0)
      else report_mismatch("empty_dump word count", 32'h0, sig_count);
    repeat (4) @(posedge clk);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
verilog/bus_pkg.sv
verilog/testutil_pkg.sv
verilog/bus.sv
verilog/ram_1p.sv
verilog/riscv_testutil.sv
verilog/compliance_harness.sv
testbench/tb_clock_gen.sv
testbench/tb_compliance_harness.sv
